//--- project.f
+incdir+dv
hw/lpc_pkg.sv
hw/wb_pkg.sv
hw/lpc_cycle_decoder.sv
hw/lpc_event_fifo.sv
hw/lpc_wb_regs.sv
hw/lpc_sniffer_top.sv
dv/lpc_sniffer_tb.sv

//--- dv/lpc_sniffer_tests.svh
// directed tests for the LPC sniffer, included into the testbench module body

	// read one register and compare it
	task automatic expect_reg(input logic [WB_AW-1:0] adr, input string name,
			input logic [WB_DW-1:0] expected);
		logic [WB_DW-1:0] v;
		wb_read(adr, v);
		check_value(name, expected, v);
	endtask

	// check status and both event views then pop the head
	task automatic pop_record();
		logic [LPC_REC_W-1:0] rec;
		logic [31:0] info;
		if (exp_q.size() == 0) begin
			$display("no expected record left to compare at %0t ns", $time);
			error_count++;
		end else begin
			rec = exp_q[0];
			info = '0;
			info[11:8] = rec[LPC_REC_W-1 -: 4];
			info[7:0] = rec[7:0];
			expect_reg(REG_STATUS, "status", status_word(exp_q.size(), exp_ovf));
			expect_reg(REG_EVT_ADDR, "evt_addr", rec[LPC_DATA_W +: LPC_ADDR_W]);
			expect_reg(REG_EVT_INFO, "evt_info", info);
			wb_write(REG_POP, '0);
			void'(exp_q.pop_front());
		end
	endtask

	// dma start followed by zero nibbles that would complete any misread cycle
	task automatic lpc_dma_cycle();
		int i;
		drive_lpc(1'b0, LPC_START_TARGET);
		drive_lpc(1'b1, type_nibble(2'b10, 1'b0));
		for (i = 0; i < 16; i++) begin
			drive_lpc(1'b1, 4'h0);
		end
		repeat (3) drive_lpc(1'b1, 4'hF);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic post_code_capture();
		int errs_start;
		errs_start = error_count;
		// reset value first
		expect_reg(REG_POST, "post_code", 32'h0000_00FF);
		lpc_io_write(16'h0080, 8'(rand_bits(8)), 0, -1);
		expect_reg(REG_POST, "post_code", {24'h0, post_expect});
		pop_record();
		report_test("post code capture", errs_start);
	endtask

	task automatic mixed_mem_cycles();
		int errs_start;
		int i;
		logic [31:0] addr;
		logic [7:0] data;
		int waits;
		errs_start = error_count;
		for (i = 0; i < 6; i++) begin
			addr = rand_bits(32);
			data = 8'(rand_bits(8));
			waits = int'(rand_bits(2));
			if (rand_bits(1) != 0) begin
				lpc_mem_write(addr, data, waits, -1);
			end else begin
				lpc_mem_read(addr, data, waits, -1);
			end
		end
		// records in bus order with the level dropping by one per pop
		while (exp_q.size() > 0) begin
			pop_record();
		end
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		report_test("memory cycles with waits", errs_start);
	endtask

	task automatic abort_recovery();
		int errs_start;
		int abort_at;
		errs_start = error_count;
		// anywhere after START within the 17 nibbles of a plain write
		abort_at = 1 + int'(rand_bits(4));
		lpc_mem_write(rand_bits(32), 8'(rand_bits(8)), 0, abort_at);
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		lpc_io_read(16'(rand_bits(16)), 8'(rand_bits(8)), int'(rand_bits(2)), -1);
		pop_record();
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		report_test("abort and recovery", errs_start);
	endtask

	task automatic skipped_cycles();
		int errs_start;
		errs_start = error_count;
		lpc_dma_cycle();
		// 1010 is the error sync
		lpc_cycle(type_nibble(LPC_CT_MEM, 1'b0), rand_bits(32), 8'(rand_bits(8)), 1, -1,
			4'b1010);
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		report_test("dma and error sync", errs_start);
	endtask

	task automatic overflow_fill();
		int errs_start;
		int i;
		errs_start = error_count;
		for (i = 0; i < 10; i++) begin
			lpc_mem_write(rand_bits(32), 8'(rand_bits(8)), 0, -1);
		end
		expect_reg(REG_STATUS, "status", status_word(DEPTH, 1'b1));
		// the first eight come back oldest first
		while (exp_q.size() > 0) begin
			pop_record();
		end
		wb_write(REG_CTRL, (32'h1 << CTRL_CAPTURE_EN) | (32'h1 << CTRL_CLR_OVF));
		exp_ovf = 1'b0;
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		report_test("overflow", errs_start);
	endtask

	task automatic capture_disable();
		int errs_start;
		errs_start = error_count;
		wb_write(REG_CTRL, '0);
		capture_on = 1'b0;
		expect_reg(REG_CTRL, "ctrl", '0);
		// a fresh POST byte that must be neither recorded nor latched
		lpc_io_write(16'h0080, ~post_expect, 1, -1);
		lpc_mem_read(rand_bits(32), 8'(rand_bits(8)), 0, -1);
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		expect_reg(REG_POST, "post_code", {24'h0, post_expect});
		wb_write(REG_CTRL, 32'h1 << CTRL_CAPTURE_EN);
		capture_on = 1'b1;
		lpc_io_write(16'h0080, 8'(rand_bits(8)), 0, -1);
		expect_reg(REG_POST, "post_code", {24'h0, post_expect});
		pop_record();
		expect_reg(REG_STATUS, "status", status_word(0, 1'b0));
		report_test("capture enable", errs_start);
	endtask

//--- dv/lpc_sniffer_tb.sv
// testbench top for the LPC sniffer; drives LPC cycles and reads the records back over Wishbone
`timescale 1ns/100ps

module lpc_sniffer_tb;
	import lpc_pkg::*;
	import wb_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int DEPTH_LOG2 = 3;
	localparam int DEPTH = 2 ** DEPTH_LOG2;
	// clocks per test, reset first
	localparam int TEST_CLOCKS = 8 + 80 + 300 + 100 + 80 + 420 + 140;
	localparam logic [31:0] LFSR_SEED = 32'h0be4_590b;
	// x^32 + x^22 + x^2 + x + 1, right shifting form
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic lpc_clock;
	logic lpc_reset;
	logic [3:0] lpc_ad;
	logic lpc_frame;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [WB_AW-1:0] wb_adr;
	logic [WB_DW-1:0] wb_dat_i;
	logic [WB_DW-1:0] wb_dat_o;
	logic wb_ack;

	// reference model of the fifo and the host registers
	logic [LPC_REC_W-1:0] exp_q[$];
	bit exp_ovf;
	bit capture_on;
	logic [7:0] post_expect;
	logic [31:0] lfsr_state;
	int error_count;
	int check_count;
	int tests_run;

	lpc_sniffer_top #(
		.FIFO_DEPTH_LOG2 (DEPTH_LOG2)
	) i_dut (
		.lpc_clock (lpc_clock),
		.lpc_reset (lpc_reset),
		.lpc_ad    (lpc_ad),
		.lpc_frame (lpc_frame),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack    (wb_ack)
	);

	initial begin
		lpc_clock = 1'b0;
		forever #(CLK_PERIOD / 2) lpc_clock = ~lpc_clock;
	end

	// watchdog, twice the planned length of all tests
	initial begin
		#(TEST_CLOCKS * 2 * CLK_PERIOD);
		$display("watchdog expired at %0t ns, the tests did not finish in time", $time);
		$display("Errors found");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_start);
		tests_run++;
		if (error_count == errs_start) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, error_count - errs_start);
		end
	endtask

	// status as the register map lays it out
	function automatic logic [31:0] status_word(input int lvl, input bit ovf);
		logic [31:0] w;
		w = '0;
		w[STAT_LEVEL_HI:0] = lvl[15:0];
		w[STAT_EMPTY] = (lvl == 0);
		w[STAT_OVERFLOW] = ovf;
		return w;
	endfunction

	function automatic logic [3:0] type_nibble(input logic [1:0] kind, input logic wr);
		logic [3:0] t;
		t = {kind, 2'b00};
		t[LPC_DIR_WRITE] = wr;
		return t;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// LPC driver
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic drive_lpc(input logic frame, input logic [3:0] ad);
		@(posedge lpc_clock);
		lpc_frame <= frame;
		lpc_ad <= ad;
	endtask

	// one complete cycle; abort_at is a nibble index, negative for none
	task automatic lpc_cycle(input logic [3:0] ct, input logic [31:0] addr,
			input logic [7:0] data, input int waits, input int abort_at,
			input logic [3:0] end_sync);
		logic [4:0] nibs[$];
		logic [31:0] exp_addr;
		int i;
		int addr_nibs;
		bit is_wr;
		bit aborted;
		addr_nibs = (ct[3:2] == LPC_CT_MEM) ? 8 : 4;
		is_wr = ct[LPC_DIR_WRITE];
		aborted = 1'b0;
		// ports are 16 bit, zero extended in the record
		exp_addr = (addr_nibs == 8) ? addr : {16'h0000, addr[15:0]};
		nibs.push_back({1'b0, LPC_START_TARGET});
		nibs.push_back({1'b1, ct});
		// msb nibble first
		for (i = addr_nibs - 1; i >= 0; i--) begin
			nibs.push_back({1'b1, addr[i*4 +: 4]});
		end
		if (is_wr) begin
			nibs.push_back({1'b1, data[3:0]});
			nibs.push_back({1'b1, data[7:4]});
		end
		// host turn-around
		nibs.push_back(5'h1F);
		nibs.push_back(5'h1F);
		// mix of short and long waits
		for (i = 0; i < waits; i++) begin
			nibs.push_back({1'b1, rand_bits(1) ? LPC_SYNC_LONG_WAIT : LPC_SYNC_SHORT_WAIT});
		end
		nibs.push_back({1'b1, end_sync});
		if (!is_wr) begin
			nibs.push_back({1'b1, data[3:0]});
			nibs.push_back({1'b1, data[7:4]});
		end
		// peripheral turn-around
		nibs.push_back(5'h1F);
		nibs.push_back(5'h1F);
		for (i = 0; i < nibs.size(); i++) begin
			if (i == abort_at) begin
				aborted = 1'b1;
				break;
			end
			drive_lpc(nibs[i][4], nibs[i][3:0]);
		end
		// host abort, frame low with 1111 for four clocks
		if (aborted) begin
			repeat (4) drive_lpc(1'b0, LPC_ABORT_CODE);
		end
		repeat (3) drive_lpc(1'b1, 4'hF);
		// fifo model, a full buffer drops and flags
		if (!aborted && (end_sync == LPC_SYNC_READY) && capture_on) begin
			if (exp_q.size() < DEPTH) begin
				exp_q.push_back({ct, exp_addr, data});
			end else begin
				exp_ovf = 1'b1;
			end
			if ((ct == type_nibble(LPC_CT_IO, 1'b1)) && (exp_addr == LPC_POST_PORT)) begin
				post_expect = data;
			end
		end
	endtask

	task automatic lpc_io_write(input logic [15:0] port, input logic [7:0] data,
			input int waits, input int abort_at);
		lpc_cycle(type_nibble(LPC_CT_IO, 1'b1), {16'h0000, port}, data, waits, abort_at,
			LPC_SYNC_READY);
	endtask

	task automatic lpc_io_read(input logic [15:0] port, input logic [7:0] data,
			input int waits, input int abort_at);
		lpc_cycle(type_nibble(LPC_CT_IO, 1'b0), {16'h0000, port}, data, waits, abort_at,
			LPC_SYNC_READY);
	endtask

	task automatic lpc_mem_write(input logic [31:0] addr, input logic [7:0] data,
			input int waits, input int abort_at);
		lpc_cycle(type_nibble(LPC_CT_MEM, 1'b1), addr, data, waits, abort_at, LPC_SYNC_READY);
	endtask

	task automatic lpc_mem_read(input logic [31:0] addr, input logic [7:0] data,
			input int waits, input int abort_at);
		lpc_cycle(type_nibble(LPC_CT_MEM, 1'b0), addr, data, waits, abort_at, LPC_SYNC_READY);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone master
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// ack is registered, so it shows up on the second clock
	task automatic wb_transfer(input logic we, input logic [WB_AW-1:0] adr,
			input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
		int n;
		bit got_ack;
		got_ack = 1'b0;
		rdat = 'x;
		@(posedge lpc_clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_i <= wdat;
		for (n = 0; (n < 8) && !got_ack; n++) begin
			@(posedge lpc_clock);
			got_ack = (wb_ack === 1'b1);
		end
		if (got_ack) begin
			rdat = wb_dat_o;
		end else begin
			$display("wishbone access to offset %h got no ack within 8 clocks at %0t ns",
				adr, $time);
			error_count++;
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
		wb_transfer(1'b0, adr, '0, dat);
	endtask

	task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
		logic [WB_DW-1:0] unused;
		wb_transfer(1'b1, adr, dat, unused);
	endtask

	`include "lpc_sniffer_tests.svh"

	initial begin
		lpc_reset <= 1'b0;
		lpc_frame <= 1'b1;
		lpc_ad <= 4'hF;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_dat_i <= '0;
		lfsr_state = LFSR_SEED;
		capture_on = 1'b1;
		exp_ovf = 1'b0;
		post_expect = 8'hFF;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		repeat (8) @(posedge lpc_clock);
		lpc_reset <= 1'b1;
		@(posedge lpc_clock);
		post_code_capture();
		mixed_mem_cycles();
		abort_recovery();
		skipped_cycles();
		overflow_fill();
		capture_disable();
		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- hw/lpc_sniffer_top.sv
// LPC sniffer top level; decoder into event FIFO, read out over the Wishbone register block
`timescale 1ns/100ps

module lpc_sniffer_top #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                     lpc_clock,
	input  logic                     lpc_reset,
	input  logic [3:0]               lpc_ad,
	input  logic                     lpc_frame,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [wb_pkg::WB_AW-1:0] wb_adr,
	input  logic [wb_pkg::WB_DW-1:0] wb_dat_i,
	output logic [wb_pkg::WB_DW-1:0] wb_dat_o,
	output logic                     wb_ack
);
	import lpc_pkg::*;

	// decoded cycle
	logic cyc_valid;
	logic [LPC_TYPE_W-1:0] cyc_type_dir;
	logic [LPC_ADDR_W-1:0] cyc_addr;
	logic [LPC_DATA_W-1:0] cyc_data;

	// fifo read side
	logic [LPC_REC_W-1:0] head_rec;
	logic empty;
	logic [FIFO_DEPTH_LOG2:0] level;
	logic overflow;

	// host control
	logic pop;
	logic clr_ovf;
	logic capture_en;

	lpc_cycle_decoder i_decoder (
		.lpc_clock    (lpc_clock),
		.lpc_reset    (lpc_reset),
		.lpc_ad       (lpc_ad),
		.lpc_frame    (lpc_frame),
		.capture_en   (capture_en),
		.cyc_valid    (cyc_valid),
		.cyc_type_dir (cyc_type_dir),
		.cyc_addr     (cyc_addr),
		.cyc_data     (cyc_data)
	);

	// record packed type, address, data from the top
	lpc_event_fifo #(
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) i_fifo (
		.lpc_clock (lpc_clock),
		.lpc_reset (lpc_reset),
		.wr_en     (cyc_valid),
		.wr_rec    ({cyc_type_dir, cyc_addr, cyc_data}),
		.pop       (pop),
		.clr_ovf   (clr_ovf),
		.head_rec  (head_rec),
		.empty     (empty),
		.level     (level),
		.overflow  (overflow)
	);

	lpc_wb_regs #(
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) i_regs (
		.lpc_clock    (lpc_clock),
		.lpc_reset    (lpc_reset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack       (wb_ack),
		.head_rec     (head_rec),
		.empty        (empty),
		.level        (level),
		.overflow     (overflow),
		.cyc_valid    (cyc_valid),
		.cyc_type_dir (cyc_type_dir),
		.cyc_addr     (cyc_addr),
		.cyc_data     (cyc_data),
		.pop          (pop),
		.clr_ovf      (clr_ovf),
		.capture_en   (capture_en)
	);

endmodule

//--- hw/lpc_wb_regs.sv
// Wishbone classic slave for the sniffer: status, event views, pop, control and POST code
`timescale 1ns/100ps

module lpc_wb_regs #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                          lpc_clock,
	input  logic                          lpc_reset,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [wb_pkg::WB_AW-1:0]      wb_adr,
	input  logic [wb_pkg::WB_DW-1:0]      wb_dat_i,
	output logic [wb_pkg::WB_DW-1:0]      wb_dat_o,
	output logic                          wb_ack,
	input  logic [lpc_pkg::LPC_REC_W-1:0]  head_rec,
	input  logic                          empty,
	input  logic [FIFO_DEPTH_LOG2:0]      level,
	input  logic                          overflow,
	input  logic                          cyc_valid,
	input  logic [lpc_pkg::LPC_TYPE_W-1:0] cyc_type_dir,
	input  logic [lpc_pkg::LPC_ADDR_W-1:0] cyc_addr,
	input  logic [lpc_pkg::LPC_DATA_W-1:0] cyc_data,
	output logic                          pop,
	output logic                          clr_ovf,
	output logic                          capture_en
);
	import lpc_pkg::*;
	import wb_pkg::*;

	logic wb_req;
	logic wr_req;
	logic rd_req;

	// head record split into its fields
	logic [LPC_TYPE_W-1:0] head_type;
	logic [LPC_ADDR_W-1:0] head_addr;
	logic [LPC_DATA_W-1:0] head_data;

	logic [STAT_LEVEL_HI:0] level_ext;
	logic [WB_DW-1:0] rd_mux;
	logic [7:0] post_code;
	logic post_hit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// new request only while ack is low
	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = wb_req && wb_we;
	assign rd_req = wb_req && !wb_we;

	assign {head_type, head_addr, head_data} = head_rec;
	assign level_ext = {{(STAT_LEVEL_HI - FIFO_DEPTH_LOG2){1'b0}}, level};

	// io write to port 0x80
	assign post_hit = cyc_valid
		&& (cyc_type_dir[3:2] == LPC_CT_IO)
		&& cyc_type_dir[LPC_DIR_WRITE]
		&& (cyc_addr == LPC_POST_PORT);

	// read data select
	always_comb begin
		rd_mux = '0;
		case (wb_adr)
			REG_STATUS: begin
				rd_mux[STAT_LEVEL_HI:0] = level_ext;
				rd_mux[STAT_EMPTY] = empty;
				rd_mux[STAT_OVERFLOW] = overflow;
			end
			REG_EVT_ADDR: begin
				rd_mux = head_addr;
			end
			REG_EVT_INFO: begin
				rd_mux[INFO_TYPE_LSB +: LPC_TYPE_W] = head_type;
				rd_mux[LPC_DATA_W-1:0] = head_data;
			end
			REG_POST: begin
				rd_mux[7:0] = post_code;
			end
			// clear bit reads back as zero
			REG_CTRL: begin
				rd_mux[CTRL_CAPTURE_EN] = capture_en;
			end
			// pop and unmapped offsets read zero
			default: begin
				rd_mux = '0;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge lpc_clock) begin
		if (!lpc_reset) begin
			wb_ack <= 1'b0;
			pop <= 1'b0;
			clr_ovf <= 1'b0;
			capture_en <= 1'b1;
			post_code <= 8'hFF;
		end else begin
			wb_ack <= wb_req;
			// pulses line up with the ack clock
			pop <= wr_req && (wb_adr == REG_POP);
			clr_ovf <= wr_req && (wb_adr == REG_CTRL) && wb_dat_i[CTRL_CLR_OVF];
			if (wr_req && (wb_adr == REG_CTRL)) begin
				capture_en <= wb_dat_i[CTRL_CAPTURE_EN];
			end
			if (post_hit) begin
				post_code <= cyc_data;
			end
		end
	end

	// read data valid with ack
	always_ff @(posedge lpc_clock) begin
		if (rd_req) begin
			wb_dat_o <= rd_mux;
		end
	end

endmodule

//--- hw/lpc_event_fifo.sv
// circular record buffer between decoder and host registers; drops on full, sticky overflow
`timescale 1ns/100ps

module lpc_event_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 3
) (
	input  logic                         lpc_clock,
	input  logic                         lpc_reset,
	input  logic                         wr_en,
	input  logic [lpc_pkg::LPC_REC_W-1:0] wr_rec,
	input  logic                         pop,
	input  logic                         clr_ovf,
	output logic [lpc_pkg::LPC_REC_W-1:0] head_rec,
	output logic                         empty,
	output logic [FIFO_DEPTH_LOG2:0]     level,
	output logic                         overflow
);
	import lpc_pkg::*;

	localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;
	// level value when every slot is taken
	localparam logic [FIFO_DEPTH_LOG2:0] LEVEL_FULL = {1'b1, {FIFO_DEPTH_LOG2{1'b0}}};

	logic [LPC_REC_W-1:0] mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (level == LEVEL_FULL);
	assign empty = (level == '0);
	// no back-pressure, a full buffer simply loses the record
	assign do_wr = wr_en && !full;
	assign do_rd = pop && !empty;
	// head is always on the read side
	assign head_rec = mem[rd_ptr];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and level
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge lpc_clock) begin
		if (!lpc_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
			// new loss beats a clear on the same clock
			if (wr_en && full) begin
				overflow <= 1'b1;
			end else if (clr_ovf) begin
				overflow <= 1'b0;
			end
		end
	end

	// storage
	always_ff @(posedge lpc_clock) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_rec;
		end
	end

endmodule

//--- hw/lpc_cycle_decoder.sv
// passive LPC cycle decoder; follows lpc_ad/lpc_frame and pulses cyc_valid per finished cycle
`timescale 1ns/100ps

module lpc_cycle_decoder (
	input  logic                          lpc_clock,
	input  logic                          lpc_reset,
	input  logic [3:0]                    lpc_ad,
	input  logic                          lpc_frame,
	input  logic                          capture_en,
	output logic                          cyc_valid,
	output logic [lpc_pkg::LPC_TYPE_W-1:0] cyc_type_dir,
	output logic [lpc_pkg::LPC_ADDR_W-1:0] cyc_addr,
	output logic [lpc_pkg::LPC_DATA_W-1:0] cyc_data
);
	import lpc_pkg::*;

	// current phase of the cycle
	lpc_state_t state;
	// nibbles left in the phase, minus one
	logic [2:0] nib_cnt;

	logic last_nib;
	logic abort_seen;
	logic start_seen;
	logic is_write;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus conditions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign last_nib = (nib_cnt == 3'd0);
	// abort wins in every state
	assign abort_seen = !lpc_frame && (lpc_ad == LPC_ABORT_CODE);
	assign start_seen = !lpc_frame && (lpc_ad == LPC_START_TARGET);
	// latched type nibble decides data order
	assign is_write = cyc_type_dir[LPC_DIR_WRITE];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge lpc_clock) begin
		if (!lpc_reset) begin
			state <= st_idle;
			nib_cnt <= 3'd0;
			cyc_valid <= 1'b0;
		end else begin
			// single clock pulse
			cyc_valid <= 1'b0;
			if (abort_seen) begin
				state <= st_idle;
			end else begin
				case (state)
					st_idle: begin
						if (start_seen) begin
							state <= st_cyctype;
						end
					end
					st_cyctype: begin
						if (!lpc_frame) begin
							// frame stretched, only a repeated START keeps us here
							if (!start_seen) begin
								state <= st_idle;
							end
						end else if (lpc_ad[3:2] == LPC_CT_IO) begin
							// 16 bit port address
							state <= st_addr;
							nib_cnt <= 3'd3;
						end else if (lpc_ad[3:2] == LPC_CT_MEM) begin
							// 32 bit memory address
							state <= st_addr;
							nib_cnt <= 3'd7;
						end else begin
							// dma and reserved, skip
							state <= st_idle;
						end
					end
					st_addr: begin
						nib_cnt <= nib_cnt - 3'd1;
						if (last_nib) begin
							nib_cnt <= 3'd1;
							// write data comes before TAR
							state <= is_write ? st_data_wr : st_tar_host;
						end
					end
					st_data_wr: begin
						nib_cnt <= nib_cnt - 3'd1;
						if (last_nib) begin
							nib_cnt <= 3'd1;
							state <= st_tar_host;
						end
					end
					st_tar_host: begin
						nib_cnt <= nib_cnt - 3'd1;
						if (last_nib) begin
							state <= st_sync;
						end
					end
					st_sync: begin
						case (lpc_ad)
							LPC_SYNC_READY: begin
								nib_cnt <= 3'd1;
								// read data follows sync
								state <= is_write ? st_tar_peri : st_data_rd;
							end
							// wait states, no limit
							LPC_SYNC_SHORT_WAIT, LPC_SYNC_LONG_WAIT: begin
								state <= st_sync;
							end
							// error or unknown sync, drop the cycle
							default: begin
								state <= st_idle;
							end
						endcase
					end
					st_data_rd: begin
						nib_cnt <= nib_cnt - 3'd1;
						if (last_nib) begin
							nib_cnt <= 3'd1;
							state <= st_tar_peri;
						end
					end
					st_tar_peri: begin
						nib_cnt <= nib_cnt - 3'd1;
						if (last_nib) begin
							// cycle complete, report unless capture is off
							state <= st_idle;
							cyc_valid <= capture_en;
						end
					end
					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// payload capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge lpc_clock) begin
		case (state)
			st_cyctype: begin
				if (lpc_frame) begin
					cyc_type_dir <= lpc_ad;
					// i/o address ends up zero extended
					cyc_addr <= '0;
				end
			end
			// msb nibble first
			st_addr: begin
				cyc_addr <= {cyc_addr[LPC_ADDR_W-5:0], lpc_ad};
			end
			// low nibble first, shifts down
			st_data_wr, st_data_rd: begin
				cyc_data <= {lpc_ad, cyc_data[LPC_DATA_W-1:4]};
			end
			default: begin
			end
		endcase
	end

endmodule

//--- hw/wb_pkg.sv
// host-side register map and field positions of the Wishbone slave; import where needed
package wb_pkg;

	// bus widths
	parameter int WB_DW = 32;
	parameter int WB_AW = 8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register offsets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	parameter logic [WB_AW-1:0] REG_STATUS = 8'h00;
	parameter logic [WB_AW-1:0] REG_EVT_ADDR = 8'h04;
	parameter logic [WB_AW-1:0] REG_EVT_INFO = 8'h08;
	parameter logic [WB_AW-1:0] REG_POP = 8'h0C;
	parameter logic [WB_AW-1:0] REG_POST = 8'h10;
	parameter logic [WB_AW-1:0] REG_CTRL = 8'h14;

	// control bits
	parameter int CTRL_CAPTURE_EN = 0;
	// write one to clear overflow
	parameter int CTRL_CLR_OVF = 1;

	// status fields, level occupies 15:0
	parameter int STAT_LEVEL_HI = 15;
	parameter int STAT_EMPTY = 16;
	parameter int STAT_OVERFLOW = 17;

	// event info, type nibble above the data byte
	parameter int INFO_TYPE_LSB = 8;

endpackage

//--- hw/lpc_pkg.sv
// LPC bus-side constants, decoder state encoding and event record layout; import where needed
package lpc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// start of a target cycle, frame low
	parameter logic [3:0] LPC_START_TARGET = 4'b0000;
	// host abort, also with frame low
	parameter logic [3:0] LPC_ABORT_CODE = 4'b1111;

	// cycle type sits in bits 3:2 of the type nibble
	parameter logic [1:0] LPC_CT_IO = 2'b00;
	parameter logic [1:0] LPC_CT_MEM = 2'b01;
	// direction bit in the same nibble, one means write
	parameter int LPC_DIR_WRITE = 1;

	// sync codes from the peripheral
	parameter logic [3:0] LPC_SYNC_READY = 4'b0000;
	parameter logic [3:0] LPC_SYNC_SHORT_WAIT = 4'b0101;
	parameter logic [3:0] LPC_SYNC_LONG_WAIT = 4'b0110;

	// POST code port on the I/O side
	parameter logic [31:0] LPC_POST_PORT = 32'h0000_0080;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoder states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		st_idle,
		st_cyctype,
		st_addr,
		st_data_wr,
		st_tar_host,
		st_sync,
		st_data_rd,
		st_tar_peri
	} lpc_state_t;

	// record fields, top down: type nibble, address, data
	parameter int LPC_TYPE_W = 4;
	parameter int LPC_ADDR_W = 32;
	parameter int LPC_DATA_W = 8;
	parameter int LPC_REC_W = LPC_TYPE_W + LPC_ADDR_W + LPC_DATA_W;

endpackage
